// ==== common/hdc_macros.svh ====
`ifndef HDC_MACROS_SVH
`define HDC_MACROS_SVH

// bits held by one lane, one slice of the hypervector
`define HDC_LANE_W 32

// number of lanes working in lockstep
`define HDC_LANES 4

// full hypervector width across all lanes
`define HDC_VEC_W (`HDC_LANE_W * `HDC_LANES)

// item memory depth per lane and its address width
`define HDC_ITEMS 16
`define HDC_ADDR_W 4

// signed bundler counter, one per hypervector bit
`define HDC_CNT_W 6

// item generator feedback taps 32, 22, 2, 1
`define HDC_LFSR_TAPS 32'h8020_0003

`endif

// ==== common/hdc_pkg.sv ====
package hdc_pkg;

    // opcodes carried in bits 15:12 of an instruction word
    typedef enum logic [3:0] {
        op_nop   = 4'd0,
        op_gen   = 4'd1,
        op_load  = 4'd2,
        op_lrotr = 4'd3,
        op_lrotl = 4'd4,
        op_lxor  = 4'd5,
        op_rotr  = 4'd6,
        op_rotl  = 4'd7,
        op_xorh  = 4'd8,
        op_move  = 4'd9,
        op_store = 4'd10,
        op_sign  = 4'd11,
        op_wb    = 4'd12,
        op_last  = 4'd13
    } hdc_op_e;

    // dispatcher sequencing
    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_exec,
        // last waits here until the bundle has left
        st_wait_out,
        st_ack_hold
    } disp_state_e;

    // 16-bit instruction word as sent by the host
    typedef struct packed {
        hdc_op_e     op;
        // unused field
        logic [7:0]  rsvd;
        logic [3:0]  addr;
    } hdc_inst_t;

endpackage

// ==== rtl/hdc_dispatch.sv ====
`timescale 1ns/10ps
`include "hdc_macros.svh"

module hdc_dispatch (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_req,
    input  logic [15:0]              in_data,
    input  logic                     out_busy,
    output logic                     in_ack,
    output logic                     lane_fetch,
    output logic                     lane_exec,
    output hdc_pkg::hdc_op_e         lane_op,
    output logic [`HDC_ADDR_W-1:0]   lane_addr,
    output logic [`HDC_VEC_W-1:0]    gen_vec
);

    import hdc_pkg::*;

    localparam int W = `HDC_LANE_W;

    disp_state_e   state;
    hdc_inst_t     inst;

    // item generator state and its stepping chain
    logic [W-1:0]  lfsr;
    logic [W-1:0]  step;

    function automatic logic [W-1:0] lfsr_next(input logic [W-1:0] s);
        return {s[W-2:0], ^(s & `HDC_LFSR_TAPS)};
    endfunction

    assign inst = hdc_inst_t'(in_data);

    assign lane_fetch = (state == st_fetch);
    assign in_ack     = (state == st_ack_hold);

    // exec strobe trails the fetch strobe by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            lane_exec <= 1'b0;
        end else begin
            lane_exec <= lane_fetch;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (in_req) begin
                        state <= st_fetch;
                    end
                end
                st_fetch: begin
                    state <= st_exec;
                end
                st_exec: begin
                    if (lane_op == op_last) begin
                        state <= st_wait_out;
                    end else begin
                        state <= st_ack_hold;
                    end
                end
                // bundler raises out_busy on the same edge we enter here
                st_wait_out: begin
                    if (!out_busy) begin
                        state <= st_ack_hold;
                    end
                end
                st_ack_hold: begin
                    if (!in_req) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // latch the instruction while in_req is held stable
    always_ff @(posedge clk) begin
        if (state == st_idle && in_req) begin
            lane_op   <= inst.op;
            lane_addr <= inst.addr;
        end
    end

    // slice i sees the generator after i+1 steps
    always_comb begin
        step = lfsr;
        for (int i = 0; i < `HDC_LANES; i++) begin
            step = lfsr_next(step);
            gen_vec[i*W +: W] = step;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= W'(1);
        end else if (lane_exec && lane_op == op_gen) begin
            lfsr <= gen_vec[`HDC_VEC_W-1 -: W];
        end
    end

    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (rst)
        $rose(in_ack) |-> in_req
    );

    a_strobes_apart: assert property (
        @(posedge clk) disable iff (rst)
        !(lane_fetch && lane_exec)
    );

endmodule

// ==== hdc_lane/hdc_lane.sv ====
`timescale 1ns/10ps
`include "hdc_macros.svh"

module hdc_lane (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     lane_fetch,
    input  logic                     lane_exec,
    input  hdc_pkg::hdc_op_e         lane_op,
    input  logic [`HDC_ADDR_W-1:0]   lane_addr,
    input  logic [`HDC_LANE_W-1:0]   gen_slice,
    input  logic [`HDC_LANE_W-1:0]   sign_slice,
    output logic [`HDC_LANE_W-1:0]   store_slice,
    output logic                     store_valid
);

    import hdc_pkg::*;

    localparam int W = `HDC_LANE_W;

    logic [W-1:0]            item_mem [`HDC_ITEMS];

    // operand read in the fetch cycle
    logic [W-1:0]            load_reg;
    logic [W-1:0]            acc;
    logic [W-1:0]            hold;

    // deferred write-back of the accumulator
    logic                    wb_pend;
    logic [`HDC_ADDR_W-1:0]  wb_addr;
    logic                    wb_hit;

    assign wb_hit = wb_pend && (wb_addr == lane_addr);

    // item memory: gen writes on exec, write-back lands on the next fetch
    always_ff @(posedge clk) begin
        if (lane_exec && lane_op == op_gen) begin
            item_mem[lane_addr] <= gen_slice;
        end else if (lane_fetch && wb_pend) begin
            item_mem[wb_addr] <= acc;
        end
    end

    // operand fetch, forwarded when the pending write-back targets this address
    always_ff @(posedge clk) begin
        if (lane_fetch) begin
            if (wb_hit) begin
                load_reg <= acc;
            end else begin
                load_reg <= item_mem[lane_addr];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_pend <= 1'b0;
        end else if (lane_exec && lane_op == op_wb) begin
            wb_pend <= 1'b1;
        end else if (lane_fetch) begin
            wb_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (lane_exec && lane_op == op_wb) begin
            wb_addr <= lane_addr;
        end
    end

    // accumulator and holding register
    always_ff @(posedge clk) begin
        if (rst) begin
            acc  <= '0;
            hold <= '0;
        end else if (lane_exec) begin
            case (lane_op)
                op_load: begin
                    acc <= load_reg;
                end
                op_lrotr: begin
                    acc <= {load_reg[0], load_reg[W-1:1]};
                end
                op_lrotl: begin
                    acc <= {load_reg[W-2:0], load_reg[W-1]};
                end
                op_lxor: begin
                    acc <= load_reg ^ acc;
                end
                op_rotr: begin
                    acc <= {acc[0], acc[W-1:1]};
                end
                op_rotl: begin
                    acc <= {acc[W-2:0], acc[W-1]};
                end
                op_xorh: begin
                    acc <= hold ^ acc;
                end
                op_move: begin
                    hold <= acc;
                end
                op_sign: begin
                    acc <= sign_slice;
                end
                // nop, gen, store, wb and last leave both registers alone
                default: begin
                end
            endcase
        end
    end

    // store pulses for one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            store_valid <= 1'b0;
        end else begin
            store_valid <= lane_exec && (lane_op == op_store);
        end
    end

    always_ff @(posedge clk) begin
        if (lane_exec && lane_op == op_store) begin
            store_slice <= acc;
        end
    end

    // a store is a single exec strobe, never two back to back
    a_store_pulse: assert property (
        @(posedge clk) disable iff (rst)
        store_valid |=> !store_valid
    );

endmodule

// ==== rtl/hdc_bundler.sv ====
`timescale 1ns/10ps
`include "hdc_macros.svh"

module hdc_bundler (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`HDC_VEC_W-1:0]   store_vec,
    input  logic                    store_valid,
    input  logic                    lane_exec,
    input  hdc_pkg::hdc_op_e        lane_op,
    input  logic                    out_ack,
    output logic [`HDC_VEC_W-1:0]   sign_vec,
    output logic                    out_req,
    output logic [`HDC_VEC_W-1:0]   out_data,
    output logic                    out_busy
);

    import hdc_pkg::*;

    localparam int VW = `HDC_VEC_W;
    localparam int CW = `HDC_CNT_W;

    // saturation limits of a two's complement counter
    localparam logic signed [CW-1:0] CNT_MAX = {1'b0, {(CW-1){1'b1}}};
    localparam logic signed [CW-1:0] CNT_MIN = {1'b1, {(CW-1){1'b0}}};

    logic signed [CW-1:0]  cnt [VW];
    logic                  emit;
    logic                  out_done;

    assign emit     = lane_exec && (lane_op == op_last);
    assign out_done = out_req && out_ack;

    // one vote per stored bit, clipped at both ends
    always_ff @(posedge clk) begin
        if (rst || out_done) begin
            for (int i = 0; i < VW; i++) begin
                cnt[i] <= '0;
            end
        end else if (store_valid) begin
            for (int i = 0; i < VW; i++) begin
                if (store_vec[i] && cnt[i] != CNT_MAX) begin
                    cnt[i] <= cnt[i] + 1'b1;
                end else if (!store_vec[i] && cnt[i] != CNT_MIN) begin
                    cnt[i] <= cnt[i] - 1'b1;
                end
            end
        end
    end

    // majority, a tie counts as zero
    always_comb begin
        for (int i = 0; i < VW; i++) begin
            sign_vec[i] = !cnt[i][CW-1] && (cnt[i] != '0);
        end
    end

    // result handshake, bundler is the sender
    always_ff @(posedge clk) begin
        if (rst) begin
            out_req  <= 1'b0;
            out_busy <= 1'b0;
        end else begin
            if (emit) begin
                out_req  <= 1'b1;
                out_busy <= 1'b1;
            end else if (out_done) begin
                out_req <= 1'b0;
            end else if (out_busy && !out_req && !out_ack) begin
                out_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            out_data <= sign_vec;
        end
    end

    a_out_stable: assert property (
        @(posedge clk) disable iff (rst)
        out_req |=> !out_req || $stable(out_data)
    );

endmodule

// ==== rtl/hdc_top.sv ====
`timescale 1ns/10ps
`include "hdc_macros.svh"

module hdc_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_req,
    input  logic [15:0]             in_data,
    output logic                    in_ack,
    output logic                    out_req,
    output logic [`HDC_VEC_W-1:0]   out_data,
    input  logic                    out_ack
);

    import hdc_pkg::*;

    localparam int W = `HDC_LANE_W;

    logic                    lane_fetch;
    logic                    lane_exec;
    hdc_op_e                 lane_op;
    logic [`HDC_ADDR_W-1:0]  lane_addr;
    logic [`HDC_VEC_W-1:0]   gen_vec;
    logic [`HDC_VEC_W-1:0]   store_vec;
    logic [`HDC_VEC_W-1:0]   sign_vec;
    logic                    store_valid;
    logic                    out_busy;

    hdc_dispatch i_dispatch (
        .clk        (clk),
        .rst        (rst),
        .in_req     (in_req),
        .in_data    (in_data),
        .out_busy   (out_busy),
        .in_ack     (in_ack),
        .lane_fetch (lane_fetch),
        .lane_exec  (lane_exec),
        .lane_op    (lane_op),
        .lane_addr  (lane_addr),
        .gen_vec    (gen_vec)
    );

    // lanes run in lockstep, lane 0 alone reports the store pulse
    for (genvar i = 0; i < `HDC_LANES; i++) begin : g_lane
        if (i == 0) begin : g_first
            hdc_lane i_lane (
                .clk         (clk),
                .rst         (rst),
                .lane_fetch  (lane_fetch),
                .lane_exec   (lane_exec),
                .lane_op     (lane_op),
                .lane_addr   (lane_addr),
                .gen_slice   (gen_vec[i*W +: W]),
                .sign_slice  (sign_vec[i*W +: W]),
                .store_slice (store_vec[i*W +: W]),
                .store_valid (store_valid)
            );
        end else begin : g_rest
            hdc_lane i_lane (
                .clk         (clk),
                .rst         (rst),
                .lane_fetch  (lane_fetch),
                .lane_exec   (lane_exec),
                .lane_op     (lane_op),
                .lane_addr   (lane_addr),
                .gen_slice   (gen_vec[i*W +: W]),
                .sign_slice  (sign_vec[i*W +: W]),
                .store_slice (store_vec[i*W +: W]),
                .store_valid ()
            );
        end
    end

    hdc_bundler i_bundler (
        .clk         (clk),
        .rst         (rst),
        .store_vec   (store_vec),
        .store_valid (store_valid),
        .lane_exec   (lane_exec),
        .lane_op     (lane_op),
        .out_ack     (out_ack),
        .sign_vec    (sign_vec),
        .out_req     (out_req),
        .out_data    (out_data),
        .out_busy    (out_busy)
    );

endmodule

// ==== testbench/hdc_checker.sv ====
`timescale 1ns/10ps
`include "hdc_macros.svh"

module hdc_checker (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_req,
    input  logic [15:0]            in_data,
    input  logic                   in_ack,
    input  logic                   out_req,
    input  logic [`HDC_VEC_W-1:0]  out_data,
    input  logic [2:0]             ack_delay,
    output logic                   out_ack,
    output int                     data_errors,
    output int                     proto_errors,
    output int                     open_bundles
);

    import hdc_pkg::*;

    localparam int LW     = `HDC_LANE_W;
    localparam int VW     = `HDC_VEC_W;
    localparam int CNT_HI = (1 << (`HDC_CNT_W - 1)) - 1;
    localparam int CNT_LO = -(1 << (`HDC_CNT_W - 1));

    // reference state of lanes, bundler and item generator
    logic [VW-1:0]  items [`HDC_ITEMS];
    logic [VW-1:0]  acc = '0;
    logic [VW-1:0]  hold = '0;
    logic [31:0]    gen_state = 32'd1;
    int             votes [VW] = '{default: 0};
    logic [VW-1:0]  expected [$];
    logic [VW-1:0]  exp_vec;

    // handshake tracking
    int             cyc = 0;
    int             req_cyc = 0;
    hdc_op_e        cur_op = op_nop;
    logic           req_q = 1'b0;
    logic           ack_q = 1'b0;
    logic           oreq_q = 1'b0;
    logic           rst_q = 1'b0;
    logic           out_seen = 1'b0;
    logic [VW-1:0]  held_data = '0;
    int             n_data = 0;
    int             n_proto = 0;
    int             n_open = 0;

    assign data_errors  = n_data;
    assign proto_errors = n_proto;
    assign open_bundles = n_open;

    // one step of the item generator, taps 32, 22, 2, 1 feed bit 0
    function automatic logic [31:0] gen_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // each 32-bit slice wraps on its own
    function automatic logic [VW-1:0] rotate_slices(input logic [VW-1:0] v, input logic right);
        logic [VW-1:0] r;
        logic [LW-1:0] s;
        for (int i = 0; i < `HDC_LANES; i++) begin
            s = v[i*LW +: LW];
            if (right) begin
                r[i*LW +: LW] = {s[0], s[LW-1:1]};
            end else begin
                r[i*LW +: LW] = {s[LW-2:0], s[LW-1]};
            end
        end
        return r;
    endfunction

    // ties go to zero
    function automatic logic [VW-1:0] majority();
        logic [VW-1:0] m;
        for (int i = 0; i < VW; i++) begin
            m[i] = (votes[i] > 0);
        end
        return m;
    endfunction

    task apply_instruction(input hdc_op_e op, input logic [3:0] addr);
        case (op)
            op_gen: begin
                for (int i = 0; i < `HDC_LANES; i++) begin
                    gen_state = gen_step(gen_state);
                    items[addr][i*LW +: LW] = gen_state;
                end
            end
            op_load: begin
                acc = items[addr];
            end
            op_lrotr: begin
                acc = rotate_slices(items[addr], 1'b1);
            end
            op_lrotl: begin
                acc = rotate_slices(items[addr], 1'b0);
            end
            op_lxor: begin
                acc = acc ^ items[addr];
            end
            op_rotr: begin
                acc = rotate_slices(acc, 1'b1);
            end
            op_rotl: begin
                acc = rotate_slices(acc, 1'b0);
            end
            op_xorh: begin
                acc = acc ^ hold;
            end
            op_move: begin
                hold = acc;
            end
            op_store: begin
                for (int i = 0; i < VW; i++) begin
                    if (acc[i] && votes[i] < CNT_HI) begin
                        votes[i]++;
                    end else if (!acc[i] && votes[i] > CNT_LO) begin
                        votes[i]--;
                    end
                end
            end
            op_sign: begin
                acc = majority();
            end
            op_wb: begin
                items[addr] = acc;
            end
            op_last: begin
                expected.push_back(majority());
                n_open++;
                for (int i = 0; i < VW; i++) begin
                    votes[i] = 0;
                end
            end
            default: begin
            end
        endcase
    endtask

    always @(posedge clk) begin
        if (rst) begin
            rst_q  = 1'b1;
            req_q  = 1'b0;
            ack_q  = 1'b0;
            oreq_q = 1'b0;
        end else begin
            if (rst_q && (in_ack !== 1'b0 || out_req !== 1'b0)) begin
                $display("in_ack or out_req was not low right after reset");
                n_proto++;
            end
            rst_q = 1'b0;
            if (in_req && !req_q) begin
                req_cyc  = cyc;
                cur_op   = hdc_op_e'(in_data[15:12]);
                out_seen = 1'b0;
                apply_instruction(cur_op, in_data[3:0]);
            end
            if (in_ack && !ack_q) begin
                if (cur_op == op_last) begin
                    if (!out_seen || out_req || out_ack) begin
                        $display("in_ack of a last rose before the result handshake ended");
                        n_proto++;
                    end
                end else if (cyc - req_cyc != 3) begin
                    $display("in_ack rose %0d cycles after in_req was sampled, not 3",
                             cyc - req_cyc);
                    n_proto++;
                end
            end
            if (out_req && !oreq_q) begin
                held_data = out_data;
                if (n_open == 0) begin
                    $display("out_req rose with no last instruction waiting for it");
                    n_proto++;
                end else begin
                    exp_vec  = expected.pop_front();
                    n_open--;
                    out_seen = 1'b1;
                    if (out_data !== exp_vec) begin
                        $display("** Error: out_data = %h, expected %h", out_data, exp_vec);
                        n_data++;
                    end
                end
            end else if (out_req && out_data !== held_data) begin
                $display("** Error: out_data = %h while out_req high, held %h",
                         out_data, held_data);
                n_data++;
            end
            req_q  = in_req;
            ack_q  = in_ack;
            oreq_q = out_req;
        end
        cyc++;
    end

    // receiving side of the result link, delay set by the host program
    initial begin
        out_ack = 1'b0;
        forever begin
            @(posedge clk);
            if (out_req === 1'b1) begin
                repeat (ack_delay) begin
                    @(posedge clk);
                end
                @(negedge clk);
                out_ack = 1'b1;
                @(posedge clk);
                while (out_req === 1'b1) begin
                    @(posedge clk);
                end
                @(negedge clk);
                out_ack = 1'b0;
            end
        end
    end

endmodule

// ==== testbench/tb_hdc.sv ====
`timescale 1ns/10ps
`include "hdc_macros.svh"

module tb_hdc;

    import hdc_pkg::*;

    localparam int VW           = `HDC_VEC_W;
    localparam int RESET_CYCLES = 5;
    localparam int RANDOM_INSTR = 300;
    // bound on the directed part, the leading last and the final last
    localparam int DIRECTED_INSTR = 145;
    // handshake, fetch and exec, longest output wait
    localparam int CYCLES_PER_INSTR = 4 + 2 + 10;
    localparam int CYCLE_LIMIT =
        (RANDOM_INSTR + DIRECTED_INSTR) * CYCLES_PER_INSTR + RESET_CYCLES + 200;

    logic           clk = 1'b0;
    logic           rst;
    logic           in_req;
    logic [15:0]    in_data;
    logic           in_ack;
    logic           out_req;
    logic [VW-1:0]  out_data;
    logic           out_ack;
    logic [2:0]     ack_delay;
    logic [31:0]    stim_lfsr;
    int             cycles = 0;
    int             data_errors;
    int             proto_errors;
    int             open_bundles;

    always #2 clk = ~clk;

    hdc_top i_dut (
        .clk      (clk),
        .rst      (rst),
        .in_req   (in_req),
        .in_data  (in_data),
        .in_ack   (in_ack),
        .out_req  (out_req),
        .out_data (out_data),
        .out_ack  (out_ack)
    );

    hdc_checker i_checker (
        .clk          (clk),
        .rst          (rst),
        .in_req       (in_req),
        .in_data      (in_data),
        .in_ack       (in_ack),
        .out_req      (out_req),
        .out_data     (out_data),
        .ack_delay    (ack_delay),
        .out_ack      (out_ack),
        .data_errors  (data_errors),
        .proto_errors (proto_errors),
        .open_bundles (open_bundles)
    );

    // fibonacci lfsr, taps 32, 30, 26, 25, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = {stim_lfsr[30:0],
                         stim_lfsr[31] ^ stim_lfsr[29] ^ stim_lfsr[25] ^ stim_lfsr[24]};
            r = {r[30:0], stim_lfsr[0]};
        end
        return r;
    endfunction

    // one full four-phase transfer on the host link
    task automatic issue(input hdc_op_e op, input logic [3:0] addr);
        logic [7:0] filler;
        filler = 8'(rand_bits(8));
        @(negedge clk);
        if (op == op_last) begin
            ack_delay = 3'(rand_bits(3));
        end
        in_data = {op, filler, addr};
        in_req  = 1'b1;
        @(posedge clk);
        while (in_ack !== 1'b1) begin
            @(posedge clk);
        end
        @(negedge clk);
        in_req = 1'b0;
        @(posedge clk);
        while (in_ack !== 1'b0) begin
            @(posedge clk);
        end
    endtask

    task automatic report_counts();
        $display("errors: %0d data, %0d protocol, %0d results never sent",
                 data_errors, proto_errors, open_bundles);
    endtask

    initial begin
        logic [3:0] op_bits;
        hdc_op_e    op;
        rst       = 1'b1;
        in_req    = 1'b0;
        in_data   = '0;
        ack_delay = '0;
        stim_lfsr = 32'h8ecd_3c22;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
        end
        @(negedge clk);
        rst = 1'b0;

        // nothing stored yet, so an all-zero bundle
        issue(op_last, 4'd0);
        for (int a = 0; a < `HDC_ITEMS; a++) begin
            issue(op_gen, 4'(a));
        end
        // a single item bundled gives itself
        for (int a = 0; a < `HDC_ITEMS; a++) begin
            issue(op_load, 4'(a));
            issue(op_store, 4'(a));
            issue(op_last, 4'(a));
        end

        // rotates and xor
        issue(op_load, 4'd3);
        issue(op_move, 4'd0);
        issue(op_lrotr, 4'd5);
        issue(op_xorh, 4'd0);
        issue(op_store, 4'd0);
        issue(op_last, 4'd0);
        issue(op_rotl, 4'd0);
        issue(op_rotl, 4'd0);
        issue(op_lxor, 4'd7);
        issue(op_store, 4'd0);
        issue(op_last, 4'd0);
        issue(op_lrotl, 4'd2);
        issue(op_rotr, 4'd0);
        issue(op_store, 4'd0);
        issue(op_last, 4'd0);

        // counters driven into saturation, majority fed back through sign
        issue(op_load, 4'd1);
        repeat (36) begin
            issue(op_store, 4'd0);
        end
        issue(op_load, 4'd2);
        repeat (3) begin
            issue(op_store, 4'd0);
        end
        issue(op_load, 4'd4);
        repeat (2) begin
            issue(op_store, 4'd0);
        end
        issue(op_sign, 4'd0);
        issue(op_last, 4'd0);
        issue(op_store, 4'd0);
        issue(op_last, 4'd0);

        // write-back, forwarded and landed
        issue(op_load, 4'd5);
        issue(op_rotl, 4'd0);
        issue(op_wb, 4'd9);
        issue(op_load, 4'd9);
        issue(op_store, 4'd0);
        issue(op_last, 4'd0);
        issue(op_rotr, 4'd0);
        issue(op_wb, 4'd11);
        issue(op_load, 4'd0);
        issue(op_load, 4'd11);
        issue(op_store, 4'd0);
        issue(op_last, 4'd0);

        // unused opcode codes turn into extra stores
        for (int n = 0; n < RANDOM_INSTR; n++) begin
            op_bits = 4'(rand_bits(4));
            if (op_bits > 4'd13) begin
                op = op_store;
            end else begin
                op = hdc_op_e'(op_bits);
            end
            issue(op, 4'(rand_bits(4)));
        end
        issue(op_last, 4'd0);

        repeat (4) begin
            @(posedge clk);
        end
        report_counts();
        if (data_errors == 0 && proto_errors == 0 && open_bundles == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the program did not finish within %0d cycles", cycles);
            report_counts();
            $display("Verification failed");
            $finish;
        end
    end

endmodule

// ==== filelist.f ====
+incdir+common
common/hdc_pkg.sv
rtl/hdc_dispatch.sv
hdc_lane/hdc_lane.sv
rtl/hdc_bundler.sv
rtl/hdc_top.sv
testbench/hdc_checker.sv
testbench/tb_hdc.sv

// ==== Makefile ====
TOP := tb_hdc

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		--Mdir obj_dir -f filelist.f

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Verification failed" sim.log; then exit 1; fi
	@grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
